// File: common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define XLEN      32  // Data and PC width
`define REG_AW    5   // Register address width
`define MUL_STEPS 32  // Shift-and-add iterations per MUL

`endif

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_MUL    = 5'd10,  // Handled by the iterative multiplier
        ALU_BEQ    = 5'd11,
        ALU_BNE    = 5'd12,
        ALU_PASS_B = 5'd13   // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MUL = 2'd1
    } wb_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_MUL_BUSY = 2'd1,
        ST_MUL_DONE = 2'd2
    } exec_state_e;

endpackage

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module alu import rv_pkg::*; (
    input  alu_op_e             i_alu_op,
    input  logic                i_a_sel,
    input  logic                i_b_sel,
    input  logic [`XLEN-1:0]    i_pc,
    input  logic [`XLEN-1:0]    i_data_a,
    input  logic [`XLEN-1:0]    i_data_b,
    input  logic [`XLEN-1:0]    i_imm,
    output logic [`XLEN-1:0]    o_result,
    output logic                o_branch_taken,
    output logic [`XLEN-1:0]    o_branch_target
);

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [SHW-1:0]   shamt;

    assign op_a  = i_a_sel ? i_pc : i_data_a;
    assign op_b  = i_b_sel ? i_imm : i_data_b;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_result = op_a + op_b;
            ALU_SUB:    o_result = op_a - op_b;
            ALU_AND:    o_result = op_a & op_b;
            ALU_OR:     o_result = op_a | op_b;
            ALU_XOR:    o_result = op_a ^ op_b;
            ALU_SLL:    o_result = op_a << shamt;
            ALU_SRL:    o_result = op_a >> shamt;
            ALU_SRA:    o_result = $signed(op_a) >>> shamt;
            ALU_SLT:    o_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   o_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: o_result = op_b;
            default:    o_result = op_a + op_b;  // MUL and branches do not use it
        endcase
    end

    assign o_branch_taken  = (i_alu_op == ALU_BEQ && op_a == op_b) ||
                             (i_alu_op == ALU_BNE && op_a != op_b);
    assign o_branch_target = i_pc + i_imm;

endmodule

`default_nettype wire

// File: execute/exec_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module exec_ctrl import rv_pkg::*; (
    input  logic        i_Clock,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  alu_op_e     i_alu_op,
    input  logic        i_reg_we,
    input  logic        i_branch_taken,
    input  logic        i_mul_done,
    output logic        o_stall,
    output logic        o_flush,
    output logic        o_mul_start,
    output logic        o_wb_en,
    output logic        o_retire_valid,
    output logic        o_redirect_valid
);

    exec_state_e state;
    exec_state_e state_nxt;
    logic        is_mul;

    assign is_mul = i_valid && (i_alu_op == ALU_MUL);

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt        = state;
        o_stall          = 1'b0;
        o_mul_start      = 1'b0;
        o_retire_valid   = 1'b0;
        o_redirect_valid = 1'b0;
        case (state)
            ST_IDLE: begin
                if (is_mul) begin
                    o_stall     = 1'b1;  // Hold operands for the start edge
                    o_mul_start = 1'b1;
                    state_nxt   = ST_MUL_BUSY;
                end else if (i_valid) begin
                    o_retire_valid   = 1'b1;
                    o_redirect_valid = i_branch_taken;
                end
            end
            ST_MUL_BUSY: begin
                o_stall = 1'b1;
                if (i_mul_done)
                    state_nxt = ST_MUL_DONE;
            end
            ST_MUL_DONE: begin
                o_retire_valid = 1'b1;  // Product is final, pipe moves again
                state_nxt      = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign o_flush = o_redirect_valid;
    assign o_wb_en = o_retire_valid && i_reg_we;

    a_done_retires: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        i_mul_done |=> o_retire_valid && !o_stall)
        else $error("MUL did not retire right after the multiplier finished");

endmodule

`default_nettype wire

// File: execute/mul_iter.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module mul_iter (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic [`XLEN-1:0]    i_multiplicand,
    input  logic [`XLEN-1:0]    i_multiplier,
    output logic                o_done,
    output logic [`XLEN-1:0]    o_product   // Low half only
);

    localparam int CNT_W = $clog2(`MUL_STEPS + 1);

    logic             busy;
    logic [CNT_W-1:0] steps_left;
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic [`XLEN-1:0] acc;

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            steps_left <= '0;
        end else if (i_start) begin
            busy       <= 1'b1;
            steps_left <= CNT_W'(`MUL_STEPS - 1);  // Step 0 runs on the start edge
        end else if (busy) begin
            busy       <= (steps_left != CNT_W'(1));
            steps_left <= steps_left - 1'b1;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_start) begin
            acc    <= i_multiplier[0] ? i_multiplicand : '0;
            mcand  <= i_multiplicand << 1;
            mplier <= i_multiplier >> 1;
        end else if (busy) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // High during the cycle whose edge performs the final step
    assign o_done    = busy && (steps_left == CNT_W'(1));
    assign o_product = acc;

    a_no_restart: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        i_start |-> !busy)
        else $error("multiplier restarted while busy");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -Mdir obj_dir -f tb.f &&
./obj_dir/Vtb_core || exit 1

// File: src/core_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module core_top import rv_pkg::*; (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  logic                i_inst_valid,
    input  logic [31:0]         i_inst,
    input  logic [`XLEN-1:0]    i_inst_pc,
    input  logic [2:0]          i_inst_tag,
    output logic                o_inst_ready,
    output logic                o_retire_valid,
    output logic [2:0]          o_retire_tag,
    output logic [`REG_AW-1:0]  o_retire_rd,
    output logic [`XLEN-1:0]    o_retire_data,
    output logic                o_retire_we,
    output logic                o_redirect_valid,
    output logic [`XLEN-1:0]    o_redirect_pc
);

    // ID stage
    logic [`REG_AW-1:0] id_rs1, id_rs2, id_rd;
    logic [`XLEN-1:0]   id_imm, id_data_a, id_data_b;
    alu_op_e            id_alu_op;
    wb_sel_e            id_wb_sel;
    logic               id_a_sel, id_b_sel, id_reg_we, id_branch, id_illegal;

    // EX stage
    logic               ex_valid, ex_a_sel, ex_b_sel, ex_reg_we, ex_branch;
    logic [2:0]         ex_tag;
    logic [`REG_AW-1:0] ex_rd;
    logic [`XLEN-1:0]   ex_pc, ex_imm, ex_data_a, ex_data_b;
    alu_op_e            ex_alu_op;
    wb_sel_e            ex_wb_sel;

    logic [`XLEN-1:0]   alu_result, mul_product, wb_data;
    logic               alu_taken, mul_done, mul_start;
    logic               stall, flush, wb_en;

    decode_unit decode_unit_i (
        .i_inst(i_inst), .o_rs1(id_rs1), .o_rs2(id_rs2), .o_rd(id_rd),
        .o_imm(id_imm), .o_alu_op(id_alu_op), .o_a_sel(id_a_sel), .o_b_sel(id_b_sel),
        .o_reg_we(id_reg_we), .o_wb_sel(id_wb_sel), .o_branch(id_branch),
        .o_illegal(id_illegal)
    );

    reg_file reg_file_i (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_rs1(id_rs1), .i_rs2(id_rs2),
        .i_wr_addr(ex_rd), .i_wr_data(wb_data), .i_wr_en(wb_en),
        .o_rs1_data(id_data_a), .o_rs2_data(id_data_b)
    );

    id_ex_reg id_ex_reg_i (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_stall(stall), .i_flush(flush),
        .i_valid(i_inst_valid && !id_illegal),  // Illegal encodings enter as bubbles
        .i_tag(i_inst_tag), .i_pc(i_inst_pc), .i_rd(id_rd), .i_imm(id_imm),
        .i_data_a(id_data_a), .i_data_b(id_data_b), .i_alu_op(id_alu_op),
        .i_a_sel(id_a_sel), .i_b_sel(id_b_sel), .i_reg_we(id_reg_we),
        .i_wb_sel(id_wb_sel), .i_branch(id_branch),
        .o_valid(ex_valid), .o_tag(ex_tag), .o_pc(ex_pc), .o_rd(ex_rd), .o_imm(ex_imm),
        .o_data_a(ex_data_a), .o_data_b(ex_data_b), .o_alu_op(ex_alu_op),
        .o_a_sel(ex_a_sel), .o_b_sel(ex_b_sel), .o_reg_we(ex_reg_we),
        .o_wb_sel(ex_wb_sel), .o_branch(ex_branch)
    );

    alu alu_i (
        .i_alu_op(ex_alu_op), .i_a_sel(ex_a_sel), .i_b_sel(ex_b_sel), .i_pc(ex_pc),
        .i_data_a(ex_data_a), .i_data_b(ex_data_b), .i_imm(ex_imm),
        .o_result(alu_result), .o_branch_taken(alu_taken),
        .o_branch_target(o_redirect_pc)
    );

    mul_iter mul_iter_i (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_start(mul_start),
        .i_multiplicand(ex_data_a), .i_multiplier(ex_data_b),
        .o_done(mul_done), .o_product(mul_product)
    );

    exec_ctrl exec_ctrl_i (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_valid(ex_valid), .i_alu_op(ex_alu_op),
        .i_reg_we(ex_reg_we), .i_branch_taken(ex_branch && alu_taken),
        .i_mul_done(mul_done), .o_stall(stall), .o_flush(flush),
        .o_mul_start(mul_start), .o_wb_en(wb_en), .o_retire_valid(o_retire_valid),
        .o_redirect_valid(o_redirect_valid)
    );

    assign wb_data       = (ex_wb_sel == WB_MUL) ? mul_product : alu_result;
    assign o_inst_ready  = !stall;
    assign o_retire_tag  = ex_tag;
    assign o_retire_rd   = ex_rd;
    assign o_retire_data = wb_data;
    assign o_retire_we   = wb_en;

endmodule

`default_nettype wire

// File: src/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module decode_unit import rv_pkg::*; (
    input  logic [31:0]          i_inst,
    output logic [`REG_AW-1:0]   o_rs1,
    output logic [`REG_AW-1:0]   o_rs2,
    output logic [`REG_AW-1:0]   o_rd,
    output logic [`XLEN-1:0]     o_imm,
    output alu_op_e              o_alu_op,
    output logic                 o_a_sel,    // 1 selects PC
    output logic                 o_b_sel,    // 1 selects immediate
    output logic                 o_reg_we,
    output wb_sel_e              o_wb_sel,
    output logic                 o_branch,
    output logic                 o_illegal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];
    assign o_rd   = i_inst[11:7];

    always_comb begin
        o_imm     = '0;
        o_alu_op  = ALU_ADD;
        o_a_sel   = 1'b0;
        o_b_sel   = 1'b0;
        o_reg_we  = 1'b0;
        o_wb_sel  = WB_ALU;
        o_branch  = 1'b0;
        o_illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: o_alu_op = ALU_SLL;
                    {7'b0000000, 3'b010}: o_alu_op = ALU_SLT;
                    {7'b0000000, 3'b011}: o_alu_op = ALU_SLTU;
                    {7'b0000000, 3'b100}: o_alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: o_alu_op = ALU_SRL;
                    {7'b0100000, 3'b101}: o_alu_op = ALU_SRA;
                    {7'b0000000, 3'b110}: o_alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: o_alu_op = ALU_AND;
                    {7'b0000001, 3'b000}: begin
                        o_alu_op = ALU_MUL;
                        o_wb_sel = WB_MUL;
                    end
                    default: o_illegal = 1'b1;  // Other M ops not supported
                endcase
            end
            OPC_OP_IMM: begin
                o_imm    = {{20{i_inst[31]}}, i_inst[31:20]};  // I-type
                o_b_sel  = 1'b1;
                o_reg_we = 1'b1;
                case (funct3)
                    3'b000:  o_alu_op = ALU_ADD;
                    3'b010:  o_alu_op = ALU_SLT;
                    3'b100:  o_alu_op = ALU_XOR;
                    3'b110:  o_alu_op = ALU_OR;
                    3'b111:  o_alu_op = ALU_AND;
                    default: o_illegal = 1'b1;  // No immediate shifts or SLTIU
                endcase
            end
            OPC_LUI: begin
                o_imm    = {i_inst[31:12], 12'b0};  // U-type
                o_b_sel  = 1'b1;
                o_reg_we = 1'b1;
                o_alu_op = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                o_imm    = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                            i_inst[30:25], i_inst[11:8], 1'b0};  // B-type
                o_branch = 1'b1;
                case (funct3)
                    3'b000:  o_alu_op = ALU_BEQ;
                    3'b001:  o_alu_op = ALU_BNE;
                    default: o_illegal = 1'b1;
                endcase
            end
            default: o_illegal = 1'b1;
        endcase
        if (o_illegal || o_rd == '0)
            o_reg_we = 1'b0;  // x0 is never written
    end

    // Supported opcodes must never leave control outputs undriven
    always_comb begin
        if (opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_BRANCH})
            a_known: assert final (!$isunknown({o_imm, o_alu_op, o_b_sel, o_reg_we,
                                                 o_wb_sel, o_branch, o_illegal}))
                else $error("decode outputs unknown for inst %h", i_inst);
    end

endmodule

`default_nettype wire

// File: src/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module id_ex_reg import rv_pkg::*; (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic                i_valid,
    input  logic [2:0]          i_tag,     // Debug tag
    input  logic [`XLEN-1:0]    i_pc,
    input  logic [`REG_AW-1:0]  i_rd,
    input  logic [`XLEN-1:0]    i_imm,
    input  logic [`XLEN-1:0]    i_data_a,
    input  logic [`XLEN-1:0]    i_data_b,
    input  alu_op_e             i_alu_op,
    input  logic                i_a_sel,
    input  logic                i_b_sel,
    input  logic                i_reg_we,
    input  wb_sel_e             i_wb_sel,
    input  logic                i_branch,
    output logic                o_valid,
    output logic [2:0]          o_tag,
    output logic [`XLEN-1:0]    o_pc,
    output logic [`REG_AW-1:0]  o_rd,
    output logic [`XLEN-1:0]    o_imm,
    output logic [`XLEN-1:0]    o_data_a,
    output logic [`XLEN-1:0]    o_data_b,
    output alu_op_e             o_alu_op,
    output logic                o_a_sel,
    output logic                o_b_sel,
    output logic                o_reg_we,
    output wb_sel_e             o_wb_sel,
    output logic                o_branch
);

    // Valid and write enable decide whether EX does anything
    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_reg_we <= 1'b0;
        end else if (i_flush) begin
            o_valid  <= 1'b0;  // Wrong-path instruction becomes a bubble
            o_reg_we <= 1'b0;
        end else if (!i_stall) begin
            o_valid  <= i_valid;
            o_reg_we <= i_reg_we;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (!i_stall) begin
            o_tag    <= i_tag;
            o_pc     <= i_pc;
            o_rd     <= i_rd;
            o_imm    <= i_imm;
            o_data_a <= i_data_a;
            o_data_b <= i_data_b;
            o_alu_op <= i_alu_op;
            o_a_sel  <= i_a_sel;
            o_b_sel  <= i_b_sel;
            o_wb_sel <= i_wb_sel;
            o_branch <= i_branch;
        end
    end

    // A branch can only resolve while the pipe is moving
    a_no_flush_stall: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        !(i_flush && i_stall))
        else $error("flush and stall asserted together");

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module reg_file (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  logic [`REG_AW-1:0]  i_rs1,
    input  logic [`REG_AW-1:0]  i_rs2,
    input  logic [`REG_AW-1:0]  i_wr_addr,
    input  logic [`XLEN-1:0]    i_wr_data,
    input  logic                i_wr_en,
    output logic [`XLEN-1:0]    o_rs1_data,
    output logic [`XLEN-1:0]    o_rs2_data
);

    localparam int NREGS = 1 << `REG_AW;

    logic [`XLEN-1:0] regs [NREGS];

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle write from EX is forwarded to the ID read
    assign o_rs1_data = (i_wr_en && i_rs1 == i_wr_addr) ? i_wr_data : regs[i_rs1];
    assign o_rs2_data = (i_wr_en && i_rs2 == i_wr_addr) ? i_wr_data : regs[i_rs2];

    a_x0_zero: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        (i_rs1 != '0 || o_rs1_data == '0) && (i_rs2 != '0 || o_rs2_data == '0))
        else $error("x0 read returned nonzero data");

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/rv_pkg.sv
src/decode_unit.sv
src/reg_file.sv
src/id_ex_reg.sv
execute/alu.sv
execute/mul_iter.sv
execute/exec_ctrl.sv
src/core_top.sv
tests/tb_core.sv

// File: tests/tb_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv_defines.svh"

module tb_core;

    typedef struct packed {
        logic        valid;
        logic        mul;
        logic [2:0]  tag;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        we;
        logic        chk;     // Data is meaningful
        logic        redir;
        logic [31:0] redir_pc;
    } ex_slot_t;

    logic        i_Clock;
    logic        i_rst_n;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic [31:0] i_inst_pc;
    logic [2:0]  i_inst_tag;
    logic        o_inst_ready;
    logic        o_retire_valid;
    logic [2:0]  o_retire_tag;
    logic [4:0]  o_retire_rd;
    logic [31:0] o_retire_data;
    logic        o_retire_we;
    logic        o_redirect_valid;
    logic [31:0] o_redirect_pc;

    logic [31:0] model_regs [32];
    logic [31:0] rng_state = 32'h9503_1ef8;
    logic [31:0] cur_pc    = 32'h0;
    logic [4:0]  last_rd   = 5'd0;
    logic [2:0]  tag_cnt   = 3'd0;
    ex_slot_t    pend      = '0;  // Accepted at the last edge, in EX now
    ex_slot_t    nxt       = '0;
    ex_slot_t    exp_slot  = '0;
    logic        exp_ready  = 1'b1;
    logic        exp_retire = 1'b0;

    core_top core_top_i (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_inst_valid(i_inst_valid),
        .i_inst(i_inst), .i_inst_pc(i_inst_pc), .i_inst_tag(i_inst_tag),
        .o_inst_ready(o_inst_ready), .o_retire_valid(o_retire_valid),
        .o_retire_tag(o_retire_tag), .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data), .o_retire_we(o_retire_we),
        .o_redirect_valid(o_redirect_valid), .o_redirect_pc(o_redirect_pc)
    );

    initial begin
        i_Clock = 1'b0;
        forever #5 i_Clock = ~i_Clock;
    end

    task automatic stop_fail();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    a_ready: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_inst_ready == exp_ready)
        else begin
            $display("CHECK FAILED o_inst_ready got %h expected %h",
                     $sampled(o_inst_ready), exp_ready);
            stop_fail();
        end
    a_retire: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_retire_valid == exp_retire)
        else begin
            $display("CHECK FAILED o_retire_valid got %h expected %h",
                     $sampled(o_retire_valid), exp_retire);
            stop_fail();
        end
    a_tag: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_retire_valid |-> o_retire_tag == exp_slot.tag)
        else begin
            $display("CHECK FAILED o_retire_tag got %h expected %h",
                     $sampled(o_retire_tag), exp_slot.tag);
            stop_fail();
        end
    a_rd: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_retire_valid |-> o_retire_rd == exp_slot.rd)
        else begin
            $display("CHECK FAILED o_retire_rd got %h expected %h",
                     $sampled(o_retire_rd), exp_slot.rd);
            stop_fail();
        end
    a_we: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_retire_valid |-> o_retire_we == exp_slot.we)
        else begin
            $display("CHECK FAILED o_retire_we got %h expected %h",
                     $sampled(o_retire_we), exp_slot.we);
            stop_fail();
        end
    a_data: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_retire_valid && exp_slot.chk |-> o_retire_data == exp_slot.data)
        else begin
            $display("CHECK FAILED o_retire_data got %h expected %h",
                     $sampled(o_retire_data), exp_slot.data);
            stop_fail();
        end
    a_redir: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_redirect_valid == (exp_slot.valid && exp_slot.redir))
        else begin
            $display("CHECK FAILED o_redirect_valid got %h expected %h",
                     $sampled(o_redirect_valid), exp_slot.valid && exp_slot.redir);
            stop_fail();
        end
    a_redir_pc: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_redirect_valid |-> o_redirect_pc == exp_slot.redir_pc)
        else begin
            $display("CHECK FAILED o_redirect_pc got %h expected %h",
                     $sampled(o_redirect_pc), exp_slot.redir_pc);
            stop_fail();
        end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    // RV32I integer result by funct3
    function automatic logic [31:0] op_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        int          kind;
        r    = next_rand();
        kind = int'(next_rand() % 32'd10);
        rs1  = r[18] ? last_rd : r[9:5];  // Often reads the previous result
        f3   = r[17:15];
        case (kind)
            0, 1, 2, 3: return enc_r(((f3 == 3'd0 || f3 == 3'd5) && r[19]) ? 7'h20 : 7'h00,
                                     r[14:10], rs1, f3, r[4:0]);
            4, 5: return enc_i(r[31:20], rs1, r[21] ? 3'd7 : {r[20:19], 1'b0}, r[4:0]);
            6: return enc_u(r[31:12], r[4:0]);
            7: return enc_r(7'h01, r[14:10], rs1, 3'd0, r[4:0]);
            8: return enc_b({{3{r[31]}}, r[31:23], 1'b0}, r[19] ? rs1 : r[14:10], rs1,
                            {2'b00, r[20]});
            default: return enc_r(7'h00, last_rd, rs1, f3, r[4:0]);
        endcase
    endfunction

    // Expected EX outcome, applied to the model register file
    task automatic predict(input logic [31:0] inst, input logic [31:0] pc);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        rd  = inst[11:7];
        f3  = inst[14:12];
        a   = model_regs[inst[19:15]];
        b   = model_regs[inst[24:20]];
        imm = {{20{inst[31]}}, inst[31:20]};
        res = 32'h0;
        nxt = '0;
        nxt.valid = 1'b1;
        nxt.chk   = 1'b1;
        case (inst[6:0])
            7'h33: begin
                if (inst[25]) begin  // MUL
                    nxt.mul = 1'b1;
                    res     = a * b;
                end else begin
                    res = op_result(f3, inst[30], a, b);
                end
            end
            7'h13: res = op_result(f3, 1'b0, a, imm);
            7'h37: res = {inst[31:12], 12'h000};
            7'h63: begin
                imm          = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                nxt.chk      = 1'b0;
                nxt.redir    = (f3 == 3'd0) ? (a == b) : (a != b);
                nxt.redir_pc = pc + imm;
            end
            default: nxt.valid = 1'b0;
        endcase
        nxt.tag  = tag_cnt;
        nxt.rd   = rd;
        nxt.data = res;
        nxt.we   = (inst[6:0] != 7'h63) && (rd != 5'd0);
        if (nxt.we)
            model_regs[rd] = res;
    endtask

    // Called just after a falling edge, returns one falling edge after acceptance
    task automatic present(input logic valid, input logic [31:0] inst,
                           input logic [31:0] pc, input logic squash);
        int waited;
        i_inst_valid = valid;
        i_inst       = inst;
        i_inst_pc    = pc;
        i_inst_tag   = tag_cnt;
        exp_slot     = pend;
        if (valid && !squash)
            predict(inst, pc);
        else
            nxt = '0;
        if (pend.valid && pend.mul) begin
            exp_ready  = 1'b0;
            exp_retire = 1'b0;
            waited     = 0;
            while (!o_inst_ready) begin
                if (waited > `MUL_STEPS + 4) begin
                    $display("timeout: instruction port stayed blocked after a MUL");
                    stop_fail();
                end
                @(negedge i_Clock);
                waited++;
                if (waited == `MUL_STEPS) begin  // Retire cycle reopens the port
                    exp_ready  = 1'b1;
                    exp_retire = 1'b1;
                end
            end
        end else begin
            exp_ready  = 1'b1;
            exp_retire = pend.valid;
        end
        @(negedge i_Clock);
        pend    = nxt;
        tag_cnt = tag_cnt + 3'd1;
    endtask

    task automatic issue(input logic [31:0] inst);
        logic [31:0] target;
        present(1'b1, inst, cur_pc, 1'b0);
        last_rd = inst[11:7];
        if (pend.redir) begin
            target = pend.redir_pc;
            // Wrong-path ADDI x2 behind the branch must be squashed
            present(1'b1, enc_i(12'h7ff, 5'd1, 3'd0, 5'd2), cur_pc + 32'd4, 1'b1);
            cur_pc = target;
        end else begin
            cur_pc = cur_pc + 32'd4;
        end
    endtask

    initial begin
        #1ms;
        $display("simulation ran past its time limit");
        stop_fail();
    end

    initial begin
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'h0;
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = 32'h0;
        i_inst_pc    = 32'h0;
        i_inst_tag   = 3'd0;
        repeat (10) @(posedge i_Clock);
        @(negedge i_Clock);
        i_rst_n = 1'b1;
        @(negedge i_Clock);

        issue(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1));    // ADD x1, x2, x3 reads zeros
        issue(enc_r(7'h00, 5'd17, 5'd31, 3'd6, 5'd4));
        issue(enc_u(20'h12345, 5'd5));
        issue(enc_i(12'h678, 5'd5, 3'd0, 5'd5));        // Depends on the LUI
        issue(enc_u(20'hfedcb, 5'd6));
        issue(enc_i(12'hfff, 5'd6, 3'd0, 5'd6));
        issue(enc_r(7'h01, 5'd6, 5'd5, 3'd0, 5'd7));    // MUL x7, x5, x6
        issue(enc_r(7'h00, 5'd5, 5'd7, 3'd0, 5'd8));    // Held during the stall
        issue(enc_b(13'd16, 5'd5, 5'd5, 3'd0));         // BEQ taken
        issue(enc_b(13'd8, 5'd5, 5'd5, 3'd1));          // BNE not taken
        issue(enc_i(12'h005, 5'd5, 3'd0, 5'd0));        // Write to x0
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));

        for (int n = 0; n < 300; n++)
            issue(random_inst());

        present(1'b0, 32'h0, cur_pc, 1'b0);
        present(1'b0, 32'h0, cur_pc, 1'b0);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
